// ==== hw/led_matrix_pkg.sv ====
`default_nettype none

package led_matrix_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// panel geometry
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int PANEL_COLUMNS = 64;  // pixels per shifted row
	localparam int ROW_PAIRS = 16;      // upper and lower half scanned together
	localparam int COLOR_BITS = 6;      // binary coded brightness per color

	typedef logic [$clog2(PANEL_COLUMNS)-1:0] column_t;  // 0 to 63
	typedef logic [$clog2(ROW_PAIRS)-1:0] row_t;         // row pair 0 to 15

	// half select, then row pair, then column
	typedef logic [$bits(row_t)+$bits(column_t):0] pixel_addr_t;

	// red on top, blue at the bottom
	typedef logic [3*COLOR_BITS-1:0] pixel_t;

	// one-hot, bit k selects plane k
	typedef logic [COLOR_BITS-1:0] plane_mask_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// plane timing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef logic [9:0] oe_count_t;  // holds up to 736 for plane 5

	localparam oe_count_t OE_BASE = 10'd23;        // lit cycles of plane 0
	localparam oe_count_t OVERLAP_START = 10'd67;  // enable count that holds off the next shift

	localparam plane_mask_t PLANE_FIRST = 6'b100000;  // msb plane shifted first
	localparam plane_mask_t PLANE_LAST = 6'b000001;   // lsb plane ends the row

endpackage

`default_nettype wire

// ==== hw/scan_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// scan position shared by the sequencer, the memory and the selector
interface scan_if;
	import led_matrix_pkg::*;

	column_t column;     // column being fetched
	row_t row;           // row pair being shifted
	plane_mask_t plane;  // brightness plane being shifted
	logic load;          // pixel load window

	// sequencer side
	modport source (
		output column,
		output row,
		output plane,
		output load
	);

	// memory only needs the address
	modport mem (
		input column,
		input row
	);

	// selector needs the plane and the window
	modport sel (
		input plane,
		input load
	);

endinterface

`default_nettype wire

// ==== hw/timeout.sv ====
`timescale 1ns/1ns
`default_nettype none

module timeout #(
	parameter int COUNTER_WIDTH = 8
) (
	input wire clk_in,
	input wire reset,
	input wire start,
	input wire [COUNTER_WIDTH-1:0] value,
	output logic [COUNTER_WIDTH-1:0] counter,
	output logic running
);

	logic start_prev;  // start level seen on the last edge
	logic start_edge;

	// a start already high when reset lifts is not an edge
	assign start_edge = start && !start_prev;

	always_ff @(posedge clk_in or posedge reset) begin
		if (reset) begin
			start_prev <= 1'b1;
			counter <= '0;
		end else begin
			start_prev <= start;
			if (start_edge) begin
				counter <= value;  // reload even if still running
			end else if (counter != '0) begin
				counter <= counter - 1'b1;  // count down and park at zero
			end
		end
	end

	assign running = counter != '0;  // value cycles high per start

endmodule

`default_nettype wire

// ==== hw/matrix_scan.sv ====
`timescale 1ns/1ns
`default_nettype none

module matrix_scan #(
	parameter int COLUMNS = led_matrix_pkg::PANEL_COLUMNS
) (
	input wire clk_in,
	input wire reset,
	scan_if.source scan,
	output logic clk_pixel,
	output logic row_latch,
	output logic output_enable,
	output led_matrix_pkg::row_t row_address
);
	import led_matrix_pkg::*;

	localparam int LOAD_BITS = $clog2(COLUMNS + 1);  // room for COLUMNS itself

	logic [1:0] state;              // last two state_advance samples
	logic state_advance;            // next plane may be shifted
	logic clk_state;                // advance held for two clocks
	logic column_start;             // same condition one cycle earlier
	logic clk_pixel_load_en;        // load window
	logic clk_pixel_en;             // load window half a cycle later
	logic [1:0] row_latch_state;    // load window history on falling edges
	column_t column_address;
	row_t row_shift;                // row pair being shifted
	plane_mask_t brightness_mask;   // plane being shifted
	plane_mask_t brightness_mask_active;  // plane on the LEDs now
	oe_count_t brightness_timeout;  // enable length of the active plane
	oe_count_t brightness_counter;  // enable cycles left

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// shift window
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk_in or posedge reset) begin
		if (reset) begin
			state <= 2'b00;
		end else begin
			state <= {state[0], state_advance};
		end
	end

	assign clk_state = state == 2'b11;
	// state becomes 11 on the next edge, so the column leads the load window
	// by one cycle and covers the memory read latency
	assign column_start = state[0] && state_advance;

	timeout #(
		.COUNTER_WIDTH(LOAD_BITS)
	) timeout_load (
		.clk_in(clk_in),
		.reset(reset),
		.start(clk_state),
		.value(LOAD_BITS'(COLUMNS)),  // one cycle per column
		.counter(),
		.running(clk_pixel_load_en)
	);

	timeout #(
		.COUNTER_WIDTH($bits(column_t))
	) timeout_column (
		.clk_in(clk_in),
		.reset(reset),
		.start(column_start),
		.value(column_t'(COLUMNS - 1)),  // counts down to 0 and parks
		.counter(column_address),
		.running()
	);

	// pixel clock enable and latch history move on the falling edge
	always_ff @(negedge clk_in or posedge reset) begin
		if (reset) begin
			clk_pixel_en <= 1'b0;  // panel clock quiet
			row_latch_state <= 2'b00;
		end else begin
			clk_pixel_en <= clk_pixel_load_en;
			row_latch_state <= {row_latch_state[0], clk_pixel_load_en};
		end
	end

	assign clk_pixel = clk_in && clk_pixel_en;  // gated clk_in rising between data changes
	assign row_latch = row_latch_state == 2'b10;  // one cycle after the last column

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// enable window
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		case (brightness_mask_active)
			6'b000001: brightness_timeout = OE_BASE;
			6'b000010: brightness_timeout = OE_BASE << 1;
			6'b000100: brightness_timeout = OE_BASE << 2;
			6'b001000: brightness_timeout = OE_BASE << 3;
			6'b010000: brightness_timeout = OE_BASE << 4;
			6'b100000: brightness_timeout = OE_BASE << 5;  // 736
			default: brightness_timeout = '0;  // nothing latched yet
		endcase
	end

	timeout #(
		.COUNTER_WIDTH($bits(oe_count_t))
	) timeout_output_enable (
		.clk_in(clk_in),
		.reset(reset),
		.start(~row_latch),  // fires as the latch pulse ends
		.value(brightness_timeout),
		.counter(brightness_counter),
		.running(output_enable)
	);

	// hold off the next shift near the end of a long window
	assign state_advance = !output_enable || (brightness_counter > OVERLAP_START);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// plane and row stepping
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk_in or posedge reset) begin
		if (reset) begin
			brightness_mask <= PLANE_FIRST;  // first shift is plane 5 of row 0
			brightness_mask_active <= '0;
			row_shift <= '0;
			row_address <= '0;
		end else if (row_latch) begin
			brightness_mask_active <= brightness_mask;  // shifted plane goes live
			row_address <= row_shift;
			if (brightness_mask == PLANE_LAST) begin
				brightness_mask <= PLANE_FIRST;
				row_shift <= row_shift + 1'b1;  // wraps 15 to 0
			end else begin
				brightness_mask <= brightness_mask >> 1;
			end
		end
	end

	assign scan.column = column_address;
	assign scan.row = row_shift;
	assign scan.plane = brightness_mask;
	assign scan.load = clk_pixel_load_en;

endmodule

`default_nettype wire

// ==== hw/frame_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_buffer #(
	parameter int COLUMNS = led_matrix_pkg::PANEL_COLUMNS
) (
	input wire clk_in,
	input wire wr_en,
	input wire led_matrix_pkg::pixel_addr_t wr_addr,
	input wire led_matrix_pkg::pixel_t wr_data,
	scan_if.mem scan,
	output led_matrix_pkg::pixel_t upper,
	output led_matrix_pkg::pixel_t lower
);
	import led_matrix_pkg::*;

	localparam int DEPTH = ROW_PAIRS * COLUMNS;  // pixels per half
	localparam int INDEX_BITS = $clog2(DEPTH);

	typedef logic [INDEX_BITS-1:0] index_t;

	pixel_t upper_bank [DEPTH];  // rows 0 to 15
	pixel_t lower_bank [DEPTH];  // rows 16 to 31

	logic wr_lower;      // top address bit picks the half
	logic wr_in_range;   // column exists on this panel
	row_t wr_row;
	column_t wr_column;
	index_t wr_index;
	index_t rd_index;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// host write port
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign wr_lower = wr_addr[$bits(pixel_addr_t)-1];
	assign wr_row = wr_addr[$bits(column_t) +: $bits(row_t)];
	assign wr_column = wr_addr[$bits(column_t)-1:0];
	assign wr_in_range = int'(wr_column) < COLUMNS;
	assign wr_index = index_t'(wr_row * COLUMNS + wr_column);  // row major

	always_ff @(posedge clk_in) begin
		if (wr_en && wr_in_range && !wr_lower) begin
			upper_bank[wr_index] <= wr_data;
		end
	end

	always_ff @(posedge clk_in) begin
		if (wr_en && wr_in_range && wr_lower) begin
			lower_bank[wr_index] <= wr_data;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// scan read port
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign rd_index = index_t'(scan.row * COLUMNS + scan.column);

	// both halves of the row pair in the same cycle
	always_ff @(posedge clk_in) begin
		upper <= upper_bank[rd_index];
		lower <= lower_bank[rd_index];
	end

endmodule

`default_nettype wire

// ==== hw/pixel_select.sv ====
`timescale 1ns/1ns
`default_nettype none

module pixel_select (
	input wire clk_in,
	input wire reset,
	scan_if.sel scan,
	input wire led_matrix_pkg::pixel_t upper,
	input wire led_matrix_pkg::pixel_t lower,
	output logic r0,
	output logic g0,
	output logic b0,
	output logic r1,
	output logic g1,
	output logic b1
);
	import led_matrix_pkg::*;

	plane_mask_t plane_d;    // plane matching the memory output
	logic [2:0] upper_bits;  // r g b of the upper half
	logic [2:0] lower_bits;  // r g b of the lower half

	// set if the color has the selected plane bit
	function automatic logic plane_bit(input logic [COLOR_BITS-1:0] color,
			input plane_mask_t mask);
		return |(color & mask);
	endfunction

	// memory read takes one cycle
	always_ff @(posedge clk_in or posedge reset) begin
		if (reset) begin
			plane_d <= '0;
		end else begin
			plane_d <= scan.plane;
		end
	end

	assign upper_bits = {
		plane_bit(upper[3*COLOR_BITS-1 -: COLOR_BITS], plane_d),  // red
		plane_bit(upper[2*COLOR_BITS-1 -: COLOR_BITS], plane_d),  // green
		plane_bit(upper[COLOR_BITS-1:0], plane_d)                 // blue
	};

	assign lower_bits = {
		plane_bit(lower[3*COLOR_BITS-1 -: COLOR_BITS], plane_d),
		plane_bit(lower[2*COLOR_BITS-1 -: COLOR_BITS], plane_d),
		plane_bit(lower[COLOR_BITS-1:0], plane_d)
	};

	// data changes on the falling edge, stable for the next pixel clock
	always_ff @(negedge clk_in or posedge reset) begin
		if (reset) begin
			{r0, g0, b0} <= 3'b000;
			{r1, g1, b1} <= 3'b000;
		end else if (scan.load) begin
			{r0, g0, b0} <= upper_bits;
			{r1, g1, b1} <= lower_bits;
		end else begin
			{r0, g0, b0} <= 3'b000;  // quiet between windows
			{r1, g1, b1} <= 3'b000;
		end
	end

endmodule

`default_nettype wire

// ==== hw/led_matrix.sv ====
`timescale 1ns/1ns
`default_nettype none

module led_matrix #(
	parameter int COLUMNS = led_matrix_pkg::PANEL_COLUMNS
) (
	input wire clk_in,
	input wire reset,
	input wire wr_en,                               // host write strobe
	input wire led_matrix_pkg::pixel_addr_t wr_addr,
	input wire led_matrix_pkg::pixel_t wr_data,
	output logic r0,                                // upper half data
	output logic g0,
	output logic b0,
	output logic r1,                                // lower half data
	output logic g1,
	output logic b1,
	output logic clk_pixel,
	output logic row_latch,
	output logic output_enable,                     // high lights the row
	output led_matrix_pkg::row_t row_address
);
	import led_matrix_pkg::*;

	pixel_t upper_pixel;  // memory to selector
	pixel_t lower_pixel;

	scan_if scan ();

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// scan engine, memory and selector
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	matrix_scan #(
		.COLUMNS(COLUMNS)
	) u_matrix_scan (
		.clk_in(clk_in),
		.reset(reset),
		.scan(scan.source),
		.clk_pixel(clk_pixel),
		.row_latch(row_latch),
		.output_enable(output_enable),
		.row_address(row_address)
	);

	frame_buffer #(
		.COLUMNS(COLUMNS)
	) u_frame_buffer (
		.clk_in(clk_in),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.scan(scan.mem),
		.upper(upper_pixel),
		.lower(lower_pixel)
	);

	pixel_select u_pixel_select (
		.clk_in(clk_in),
		.reset(reset),
		.scan(scan.sel),
		.upper(upper_pixel),
		.lower(lower_pixel),
		.r0(r0),
		.g0(g0),
		.b0(b0),
		.r1(r1),
		.g1(g1),
		.b1(b1)
	);

endmodule

`default_nettype wire

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
	output logic clk_in,
	output logic reset
);

	initial begin
		clk_in = 1'b0;
		forever #50 clk_in = ~clk_in;  // 100 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (16) @(posedge clk_in);  // 16 cycles in reset
		#10 reset = 1'b0;               // released just after the edge
	end

endmodule

`default_nettype wire

// ==== verification/led_matrix_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module led_matrix_checker (
	input wire clk_in,
	input wire reset,
	input wire wr_en,
	input wire led_matrix_pkg::pixel_addr_t wr_addr,
	input wire led_matrix_pkg::pixel_t wr_data,
	input wire r0,
	input wire g0,
	input wire b0,
	input wire r1,
	input wire g1,
	input wire b1,
	input wire clk_pixel,
	input wire row_latch,
	input wire output_enable,
	input wire led_matrix_pkg::row_t row_address,
	input wire run_done,
	output int latch_count,
	output int error_count
);

	logic [17:0] model [2048];  // reference frame, host address order
	logic [5:0] lines [64];     // r0 g0 b0 r1 g1 b1 per pixel clock
	int errs [6] = '{default: 0};
	int checks [6] = '{default: 0};
	int pix_total = 0;          // pixel clocks since start
	int pix_base = 0;           // pix_total at the last latch
	int fails = 0;
	int latches = 0;
	int writes = 0;
	int wraps = 0;              // dut row_address going 15 to 0
	int skipped = 0;            // latches with a write to the shifted row
	int oe_width = 0;
	int plane_exp = 5;          // plane being shifted
	int plane_live = 5;         // plane on the LEDs
	logic [3:0] row_exp = '0;   // row pair being shifted
	logic [3:0] row_live = '0;
	logic [3:0] row_seen = '0;  // row_address after the last latch
	logic [15:0] live_dirty = '0;
	bit oe_prev = 0;
	bit disturbed = 0;
	bit row_pending = 0;
	bit reset_done = 0;
	bit reported = 0;

	assign latch_count = latches;
	assign error_count = fails;

	function automatic string test_name(input int t);
		case (t)
			0: return "shifted data";
			1: return "plane and row order";
			2: return "enable width";
			3: return "pixel count";
			4: return "live writes";
			default: return "reset state";
		endcase
	endfunction

	task automatic compare(input int test, input string name, input int expected,
			input int actual);
		checks[3'(test)]++;
		if (expected != actual) begin
			errs[3'(test)]++;
			fails++;
			$display("CHECK FAILED time %0t %s expected %0d actual %0d", $time, name,
				expected, actual);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// compare the 64 shifted columns at each row latch and step the plane
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic check_latch();
		int n;
		int bad_before;
		logic [17:0] up;
		logic [17:0] lo;
		logic [5:0] want;
		n = pix_total - pix_base;
		compare(3, "clk_pixel edges per latch", 64, n);
		if (disturbed) begin
			skipped++;  // row written while it was shifted
		end else if (n == 64) begin
			bad_before = errs[0];
			for (int k = 0; k < 64; k++) begin
				up = model[{1'b0, row_exp, 6'(63 - k)}] >> plane_exp;
				lo = model[{1'b1, row_exp, 6'(63 - k)}] >> plane_exp;
				want = {up[12], up[6], up[0], lo[12], lo[6], lo[0]};
				compare(0, $sformatf("{r0,g0,b0,r1,g1,b1} pixel clock %0d", k),
					int'(want), int'(lines[6'(pix_base + k)]));
			end
			if (live_dirty[row_exp]) begin
				checks[4]++;
				if (errs[0] != bad_before) errs[4]++;  // already counted as data
			end
		end
		pix_base = pix_total;
		row_live = row_exp;
		plane_live = plane_exp;
		row_pending = 1;
		disturbed = 0;
		latches++;
		if (plane_exp == 0) begin
			plane_exp = 5;  // next row pair
			row_exp = row_exp + 4'd1;
		end else begin
			plane_exp--;
		end
	endtask

	always @(posedge clk_pixel) begin
		lines[6'(pix_total)] = {r0, g0, b0, r1, g1, b1};  // stable since falling edge
		pix_total = pix_total + 1;
	end

	always @(posedge clk_in) begin
		if (reset || !reset_done) begin
			compare(5, "output_enable", 0, int'(output_enable));
			compare(5, "row_latch", 0, int'(row_latch));
			compare(5, "row_address", 0, int'(row_address));
			compare(5, "data lines", 0, int'({r0, g0, b0, r1, g1, b1}));
			if (!reset) begin
				reset_done = 1;  // first edge after reset checked too
				$display("test %s: %0d checks, %0d errors", test_name(5), checks[5], errs[5]);
			end
		end else begin
			if (row_pending) begin
				compare(1, "row_address", int'(row_live), int'(row_address));
				if (row_seen == 4'd15 && row_address == 4'd0) wraps++;
				row_seen = row_address;
				row_pending = 0;
			end
			if (output_enable) begin
				oe_width++;
			end else if (oe_prev) begin
				compare(2, "output_enable width", 23 << plane_live, oe_width);
				oe_width = 0;
			end
			oe_prev = output_enable;
			if (row_latch) check_latch();
		end
		if (wr_en) begin
			if (!row_latch && wr_addr[9:6] == row_exp) disturbed = 1;
			model[wr_addr] = wr_data;  // updated after the compare like the memory
			writes++;
			if (writes > 2048) live_dirty[wr_addr[9:6]] = 1'b1;
		end
		if (run_done && !reported) begin
			reported = 1;
			compare(1, "row wraps", 3, wraps);
			if (checks[4] == 0) begin
				$display("live writes: no rewritten row was compared");
				fails++;
			end
			for (int t = 0; t < 5; t++) begin
				$display("test %s: %0d checks, %0d errors", test_name(t), checks[3'(t)],
					errs[3'(t)]);
			end
			$display("latches skipped during writes: %0d", skipped);
		end
	end

endmodule

`default_nettype wire

// ==== verification/led_matrix_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module led_matrix_tb;
	import led_matrix_pkg::*;

	// 16 rows of plane widths plus overlap and shift cycles
	localparam longint FRAME_CYCLES = 16 * (23 * 63 + 6 * (67 + 64));
	localparam int LATCH_TARGET = 290;  // a bit over three frames

	logic clk_in;
	logic reset;
	logic wr_en;
	pixel_addr_t wr_addr;
	pixel_t wr_data;
	logic r0, g0, b0, r1, g1, b1;
	logic clk_pixel;
	logic row_latch;
	logic output_enable;
	row_t row_address;
	logic run_done;
	row_t target;  // row pair far from the scan
	int latch_count;
	int error_count;

	tb_clock u_clock (.clk_in(clk_in), .reset(reset));

	led_matrix #(
		.COLUMNS(64)
	) DUT (
		.clk_in(clk_in), .reset(reset), .wr_en(wr_en), .wr_addr(wr_addr),
		.wr_data(wr_data), .r0(r0), .g0(g0), .b0(b0), .r1(r1), .g1(g1), .b1(b1),
		.clk_pixel(clk_pixel), .row_latch(row_latch), .output_enable(output_enable),
		.row_address(row_address)
	);

	led_matrix_checker u_checker (
		.clk_in(clk_in), .reset(reset), .wr_en(wr_en), .wr_addr(wr_addr),
		.wr_data(wr_data), .r0(r0), .g0(g0), .b0(b0), .r1(r1), .g1(g1), .b1(b1),
		.clk_pixel(clk_pixel), .row_latch(row_latch), .output_enable(output_enable),
		.row_address(row_address), .run_done(run_done), .latch_count(latch_count),
		.error_count(error_count)
	);

	task automatic write_pixel(input pixel_addr_t addr);
		@(posedge clk_in);
		#10;
		wr_en = 1'b1;
		wr_addr = addr;
		wr_data = pixel_t'($urandom);
	endtask

	task automatic stop_writes();
		@(posedge clk_in);
		#10;
		wr_en = 1'b0;
	endtask

	initial begin
		void'($urandom(32'he6e1_2be2));
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		run_done = 1'b0;
		target = '0;
		// row pair order, so row 0 is filled before its second plane
		for (int rp = 0; rp < 16; rp++) begin
			for (int half = 0; half < 2; half++) begin
				for (int col = 0; col < 64; col++) begin
					write_pixel({1'(half), 4'(rp), 6'(col)});
				end
			end
		end
		stop_writes();
		while (latch_count < LATCH_TARGET) begin
			@(posedge clk_in);
			#10;
			if (row_latch) begin
				target = row_address + 4'd8;  // half a frame away
				repeat (4) write_pixel({1'($urandom), target, 6'($urandom)});
				stop_writes();
			end
		end
		run_done = 1'b1;
		@(posedge clk_in);
		#10;  // checker has reported on this edge
		$display("run summary: %0d latches, %0d errors", latch_count, error_count);
		if (error_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// watchdog over four frames
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		#(4 * FRAME_CYCLES * 100);
		$display("watchdog: scan did not reach %0d latches in four frames", LATCH_TARGET);
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== led_matrix.f ====
hw/led_matrix_pkg.sv
hw/scan_if.sv
hw/timeout.sv
hw/matrix_scan.sv
hw/frame_buffer.sv
hw/pixel_select.sv
hw/led_matrix.sv
verification/tb_clock.sv
verification/led_matrix_checker.sv
verification/led_matrix_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module led_matrix_tb -f led_matrix.f \
	--Mdir obj_dir -o led_matrix_sim

./obj_dir/led_matrix_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Everything OK" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
